// File: design/ibuf_defines.svh
`ifndef IBUF_DEFINES_SVH
`define IBUF_DEFINES_SVH

// number of issue slots, each slot owns its own instruction queue
`define IBUF_ISSUE_WIDTH 2

// warps in the core, spread over the slots by warp id modulo the issue width
`define IBUF_NUM_WARPS 8

// entries per slot queue, the output register counts as one of them
`define IBUF_SIZE 4

// cycles of the wrong-path drain window that follows a mispredict flush
`define IBUF_FLUSH_CYCLES 3

// instruction field widths
`define IBUF_WID_W 3
`define IBUF_WIS_W 2
`define IBUF_UUID_W 8
`define IBUF_TMASK_W 4
`define IBUF_XLEN 32
`define IBUF_NR_W 5
`define IBUF_EX_W 2
`define IBUF_OP_W 4

// one queue entry holds uuid, wis, tmask, ex, op, wb, pc, imm and three register numbers
`define IBUF_ENTRY_W (`IBUF_UUID_W + `IBUF_WIS_W + `IBUF_TMASK_W + `IBUF_EX_W + `IBUF_OP_W + 1 + 2 * `IBUF_XLEN + 3 * `IBUF_NR_W)

`endif

// File: design/ibuf_instr_pkg.sv
`include "ibuf_defines.svh"

// types for the instruction fields that travel from the decoder to issue
package ibuf_instr_pkg;

    typedef logic [`IBUF_UUID_W-1:0]  uuid_t;
    typedef logic [`IBUF_WID_W-1:0]   wid_t;
    typedef logic [`IBUF_WIS_W-1:0]   wis_t;
    typedef logic [`IBUF_TMASK_W-1:0] tmask_t;
    typedef logic [`IBUF_XLEN-1:0]    word_t;
    typedef logic [`IBUF_NR_W-1:0]    reg_num_t;

    // functional unit that will execute the instruction
    typedef enum logic [`IBUF_EX_W-1:0] {
        EX_ALU = 2'd0,
        EX_LSU = 2'd1,
        EX_SFU = 2'd2,
        EX_FPU = 2'd3
    } ex_type_e;

    // operation inside the chosen unit
    typedef enum logic [`IBUF_OP_W-1:0] {
        OP_ADD    = 4'd0,
        OP_SUB    = 4'd1,
        OP_AND    = 4'd2,
        OP_OR     = 4'd3,
        OP_LOAD   = 4'd4,
        OP_STORE  = 4'd5,
        OP_BRANCH = 4'd6,
        OP_FMA    = 4'd7
    } op_type_e;

    // layout of one queue entry, the warp id is already reduced to its in-slot index
    typedef struct packed {
        uuid_t    uuid;
        wis_t     wis;
        tmask_t   tmask;
        ex_type_e ex_type;
        op_type_e op_type;
        logic     wb;
        word_t    pc;
        word_t    imm;
        reg_num_t rd;
        reg_num_t rs1;
        reg_num_t rs2;
    } ibuf_entry_t;

endpackage

// File: design/ibuf_ctrl_pkg.sv
`include "ibuf_defines.svh"

// types for the buffer control path, slot selection and flush handling
package ibuf_ctrl_pkg;

    // flush handling has only two phases
    typedef enum logic [0:0] {
        FLUSH_IDLE  = 1'b0,
        FLUSH_DRAIN = 1'b1
    } flush_state_e;

    // index of one issue slot
    typedef logic [$clog2(`IBUF_ISSUE_WIDTH)-1:0] slot_idx_t;

    // one bit per issue slot, used for write strobes and not-full levels
    typedef logic [`IBUF_ISSUE_WIDTH-1:0] slot_vec_t;

    // drain window counter, wide enough to hold the full window length
    typedef logic [$clog2(`IBUF_FLUSH_CYCLES + 1)-1:0] win_cnt_t;

endpackage

// File: design/ibuf_slot_router.sv
`timescale 1ns/1ns
`include "ibuf_defines.svh"

// routes each decoded instruction to the queue of its issue slot
// the slot is wid modulo the issue width and the in-slot index is wid divided by it
module ibuf_slot_router import ibuf_instr_pkg::*, ibuf_ctrl_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,

    // decoder handshake and fields
    input  logic                     dec_valid,
    output logic                     dec_ready,
    input  uuid_t                    dec_uuid,
    input  wid_t                     dec_wid,
    input  tmask_t                   dec_tmask,
    input  ex_type_e                 dec_ex_type,
    input  op_type_e                 dec_op_type,
    input  logic                     dec_wb,
    input  word_t                    dec_pc,
    input  word_t                    dec_imm,
    input  reg_num_t                 dec_rd,
    input  reg_num_t                 dec_rs1,
    input  reg_num_t                 dec_rs2,

    // wrong-path drain mode from the flush FSM
    input  logic                     drop,

    // queue side
    input  slot_vec_t                slot_not_full,
    output slot_vec_t                slot_write,
    output logic [`IBUF_ENTRY_W-1:0] entry
);

    slot_idx_t   dec_slot;
    wis_t        dec_wis;
    ibuf_entry_t packed_entry;
    logic        accept;

    // the issue width is a power of two in practice so these reduce to bit slices
    assign dec_slot = slot_idx_t'(dec_wid % `IBUF_ISSUE_WIDTH);
    assign dec_wis  = wis_t'(dec_wid / `IBUF_ISSUE_WIDTH);

    // while draining, every wrong-path instruction is taken and thrown away
    // otherwise the decoder waits on the not-full level of its own slot only
    assign dec_ready = drop || slot_not_full[dec_slot];
    assign accept    = dec_valid && dec_ready && !drop;

    always_comb begin
        slot_write           = '0;
        slot_write[dec_slot] = accept;
    end

    // all slots share one entry bus and only the strobe tells them apart
    always_comb begin
        packed_entry.uuid    = dec_uuid;
        packed_entry.wis     = dec_wis;
        packed_entry.tmask   = dec_tmask;
        packed_entry.ex_type = dec_ex_type;
        packed_entry.op_type = dec_op_type;
        packed_entry.wb      = dec_wb;
        packed_entry.pc      = dec_pc;
        packed_entry.imm     = dec_imm;
        packed_entry.rd      = dec_rd;
        packed_entry.rs1     = dec_rs1;
        packed_entry.rs2     = dec_rs2;
    end

    assign entry = packed_entry;

    // an instruction belongs to exactly one slot so never more than one queue is written
    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(slot_write));

    // the decoder holds a refused instruction and its fields until it is taken
    assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid && !dec_ready |=> dec_valid && $stable(dec_uuid) && $stable(dec_wid));

endmodule

// File: design/ibuf_fifo.sv
`timescale 1ns/1ns
`include "ibuf_defines.svh"

// one slot queue, a small circular store feeding a registered output stage
// the output register is part of the capacity, so the store holds one entry less
module ibuf_fifo (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     clear,
    input  logic                     write,
    input  logic [`IBUF_ENTRY_W-1:0] entry,
    input  logic                     out_ready,
    output logic                     not_full,
    output logic                     out_valid,
    output logic [`IBUF_ENTRY_W-1:0] out_entry,
    output logic                     pop
);

    localparam int STORE_D = `IBUF_SIZE - 1;
    localparam int PTR_W   = (STORE_D > 1) ? $clog2(STORE_D) : 1;
    localparam int CNT_W   = $clog2(`IBUF_SIZE + 1);

    logic [`IBUF_ENTRY_W-1:0] store [STORE_D];
    logic [PTR_W-1:0]         rd_ptr;
    logic [PTR_W-1:0]         wr_ptr;
    logic [CNT_W-1:0]         count;
    logic [CNT_W-1:0]         count_next;
    logic [CNT_W-1:0]         store_cnt;
    logic                     out_free;
    logic                     store_empty;
    logic                     load_store;
    logic                     bypass;
    logic                     store_write;

    // wrap a store pointer, the depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        nxt = (ptr == PTR_W'(STORE_D - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    assign pop = out_valid && out_ready;

    // the output stage can take a new entry when it is empty or being popped
    assign out_free = !out_valid || out_ready;

    // count covers the store plus the output register
    assign store_cnt   = count - CNT_W'(out_valid);
    assign store_empty = (store_cnt == '0);

    // older entries in the store always go first, a write only bypasses an empty store
    assign load_store  = out_free && !store_empty;
    assign bypass      = out_free && store_empty && write;
    assign store_write = write && !bypass;

    assign count_next = count + CNT_W'(write) - CNT_W'(pop);

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            count     <= '0;
            not_full  <= 1'b1;
            out_valid <= 1'b0;
            rd_ptr    <= '0;
            wr_ptr    <= '0;
        end else begin
            count <= count_next;
            // a pop frees its place only from the next cycle on
            not_full <= (count_next < CNT_W'(`IBUF_SIZE));
            if (out_free) begin
                out_valid <= load_store || bypass;
            end
            if (load_store) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (store_write) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_write) begin
            store[wr_ptr] <= entry;
        end
        if (load_store) begin
            out_entry <= store[rd_ptr];
        end else if (bypass) begin
            out_entry <= entry;
        end
    end

    // the router must respect the registered not-full level
    assert property (@(posedge clk) disable iff (!rst_n) write |-> not_full);

    // a stalled head stays put until issue takes it or a flush removes it
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready && !clear |=> out_valid && $stable(out_entry));

endmodule

// File: design/ibuf_flush_fsm.sv
`timescale 1ns/1ns
`include "ibuf_defines.svh"

// steers the buffer through a branch mispredict flush
// the pulse clears every queue at once, then a drain window swallows
// the wrong-path instructions still coming out of the decoder
module ibuf_flush_fsm import ibuf_ctrl_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic flush,
    input  logic window_done,
    output logic clear,
    output logic window_start,
    output logic drop
);

    flush_state_e state;
    flush_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            FLUSH_IDLE: begin
                if (flush) begin
                    state_next = FLUSH_DRAIN;
                end
            end
            FLUSH_DRAIN: begin
                // a second mispredict restarts the window, so it wins over done
                if (flush) begin
                    state_next = FLUSH_DRAIN;
                end else if (window_done) begin
                    state_next = FLUSH_IDLE;
                end
            end
            default: begin
                state_next = FLUSH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= FLUSH_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // queues empty on the same edge the FSM enters the drain
    assign clear        = flush;
    assign window_start = flush;
    assign drop         = (state == FLUSH_DRAIN);

    // every flush is followed by at least a full window of dropping
    assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> drop [*`IBUF_FLUSH_CYCLES]);

    // the timer only ends a window the FSM is actually in
    assert property (@(posedge clk) disable iff (!rst_n) window_done |-> drop);

endmodule

// File: design/ibuf_window_timer.sv
`timescale 1ns/1ns
`include "ibuf_defines.svh"

// measures the drain window after a flush
// start loads the window length and the counter runs down to zero
// done marks the last cycle of the window
module ibuf_window_timer import ibuf_ctrl_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic done
);

    win_cnt_t cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (start) begin
            // a restart simply reloads the full length
            cnt <= win_cnt_t'(`IBUF_FLUSH_CYCLES);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // the count reaches one in the final cycle, zero means idle
    assign done = (cnt == win_cnt_t'(1));

    // without a restart the window ends exactly the configured number of cycles after start
    assert property (@(posedge clk) disable iff (!rst_n)
        start ##1 !start [*(`IBUF_FLUSH_CYCLES - 1)] |=> done);

endmodule

// File: design/ibuf_top.sv
`timescale 1ns/1ns
`include "ibuf_defines.svh"

// instruction buffer between the warp decoder and the issue stage
// one queue per issue slot, plus the flush FSM and its drain timer
module ibuf_top import ibuf_instr_pkg::*, ibuf_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,

    // decoder side
    input  logic     dec_valid,
    output logic     dec_ready,
    input  uuid_t    dec_uuid,
    input  wid_t     dec_wid,
    input  tmask_t   dec_tmask,
    input  ex_type_e dec_ex_type,
    input  op_type_e dec_op_type,
    input  logic     dec_wb,
    input  word_t    dec_pc,
    input  word_t    dec_imm,
    input  reg_num_t dec_rd,
    input  reg_num_t dec_rs1,
    input  reg_num_t dec_rs2,

    // issue side, one element per slot
    output logic     ibuf_valid   [`IBUF_ISSUE_WIDTH],
    input  logic     ibuf_ready   [`IBUF_ISSUE_WIDTH],
    output logic     ibuf_pop     [`IBUF_ISSUE_WIDTH],
    output uuid_t    ibuf_uuid    [`IBUF_ISSUE_WIDTH],
    output wis_t     ibuf_wis     [`IBUF_ISSUE_WIDTH],
    output tmask_t   ibuf_tmask   [`IBUF_ISSUE_WIDTH],
    output ex_type_e ibuf_ex_type [`IBUF_ISSUE_WIDTH],
    output op_type_e ibuf_op_type [`IBUF_ISSUE_WIDTH],
    output logic     ibuf_wb      [`IBUF_ISSUE_WIDTH],
    output word_t    ibuf_pc      [`IBUF_ISSUE_WIDTH],
    output word_t    ibuf_imm     [`IBUF_ISSUE_WIDTH],
    output reg_num_t ibuf_rd      [`IBUF_ISSUE_WIDTH],
    output reg_num_t ibuf_rs1     [`IBUF_ISSUE_WIDTH],
    output reg_num_t ibuf_rs2     [`IBUF_ISSUE_WIDTH]
);

    slot_vec_t                slot_write;
    slot_vec_t                slot_not_full;
    logic [`IBUF_ENTRY_W-1:0] entry;
    ibuf_entry_t              q_entry [`IBUF_ISSUE_WIDTH];
    logic                     fifo_clear;
    logic                     window_start;
    logic                     window_done;
    logic                     drop;

    ibuf_slot_router u_router (
        .clk, .rst_n, .dec_valid, .dec_ready, .dec_uuid, .dec_wid, .dec_tmask,
        .dec_ex_type, .dec_op_type, .dec_wb, .dec_pc, .dec_imm, .dec_rd, .dec_rs1,
        .dec_rs2, .drop, .slot_not_full, .slot_write, .entry
    );

    ibuf_flush_fsm u_flush_fsm (
        .clk, .rst_n, .flush, .window_done, .clear(fifo_clear), .window_start, .drop
    );

    ibuf_window_timer u_window_timer (
        .clk, .rst_n, .start(window_start), .done(window_done)
    );

    for (genvar i = 0; i < `IBUF_ISSUE_WIDTH; i++) begin : g_slot
        ibuf_fifo u_fifo (
            .clk, .rst_n, .clear(fifo_clear), .write(slot_write[i]), .entry,
            .out_ready(ibuf_ready[i]), .not_full(slot_not_full[i]),
            .out_valid(ibuf_valid[i]), .out_entry(q_entry[i]), .pop(ibuf_pop[i])
        );

        // split the queue head back into the issue fields
        assign ibuf_uuid[i]    = q_entry[i].uuid;
        assign ibuf_wis[i]     = q_entry[i].wis;
        assign ibuf_tmask[i]   = q_entry[i].tmask;
        assign ibuf_ex_type[i] = q_entry[i].ex_type;
        assign ibuf_op_type[i] = q_entry[i].op_type;
        assign ibuf_wb[i]      = q_entry[i].wb;
        assign ibuf_pc[i]      = q_entry[i].pc;
        assign ibuf_imm[i]     = q_entry[i].imm;
        assign ibuf_rd[i]      = q_entry[i].rd;
        assign ibuf_rs1[i]     = q_entry[i].rs1;
        assign ibuf_rs2[i]     = q_entry[i].rs2;
    end

endmodule

// File: sim/ibuf_model.svh
`ifndef IBUF_MODEL_SVH
`define IBUF_MODEL_SVH

// one instruction as the issue stage is expected to see it
typedef struct packed {
    logic [`IBUF_UUID_W-1:0]  uuid;
    logic [`IBUF_WIS_W-1:0]   wis;
    logic [`IBUF_TMASK_W-1:0] tmask;
    logic [`IBUF_EX_W-1:0]    ex_type;
    logic [`IBUF_OP_W-1:0]    op_type;
    logic                     wb;
    logic [`IBUF_XLEN-1:0]    pc;
    logic [`IBUF_XLEN-1:0]    imm;
    logic [`IBUF_NR_W-1:0]    rd;
    logic [`IBUF_NR_W-1:0]    rs1;
    logic [`IBUF_NR_W-1:0]    rs2;
} exp_instr_t;

// reference queues in acceptance order, the head is what issue should see
exp_instr_t exp_q [`IBUF_ISSUE_WIDTH][$];

// entries held per slot as of the last edge, not-full follows this count
int exp_occ [`IBUF_ISSUE_WIDTH];

// cycles of wrong-path dropping still ahead
int drain_left;

// traffic statistics, printed at the end of the run
int pops_seen;
int dropped_seen;

// compare one observed value with the expected one and stop on the first difference
task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
        $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        $display("Simulation finished: FAIL");
        $fatal(1, "value check of %s failed", name);
    end
endtask

// expected decoder ready, everything is taken while draining
function automatic logic exp_dec_ready(input logic [`IBUF_WID_W-1:0] wid);
    int slot;
    slot = int'(wid) % `IBUF_ISSUE_WIDTH;
    if (drain_left > 0) begin
        return 1'b1;
    end
    return exp_occ[slot] < `IBUF_SIZE;
endfunction

// advance the model by one rising edge with the values seen before that edge
task automatic model_clock(input logic flush_s, input logic xfer_s, input int slot_s,
                           input exp_instr_t instr_s,
                           input logic [`IBUF_ISSUE_WIDTH-1:0] pop_s);
    if (flush_s) begin
        // a mispredict empties every queue and swallows the transfer of the same cycle
        for (int s = 0; s < `IBUF_ISSUE_WIDTH; s++) begin
            exp_q[s].delete();
        end
        drain_left = `IBUF_FLUSH_CYCLES;
        if (xfer_s) dropped_seen++;
    end else begin
        for (int s = 0; s < `IBUF_ISSUE_WIDTH; s++) begin
            if (pop_s[s]) begin
                void'(exp_q[s].pop_front());
                pops_seen++;
            end
        end
        if (xfer_s && drain_left == 0) begin
            exp_q[slot_s].push_back(instr_s);
        end else if (xfer_s) begin
            dropped_seen++;
        end
        if (drain_left > 0) drain_left--;
    end
    // the registered occupancy only sees this edge's pops from the next cycle on
    for (int s = 0; s < `IBUF_ISSUE_WIDTH; s++) begin
        exp_occ[s] = exp_q[s].size();
    end
endtask

`endif

// File: sim/tb_ibuf.sv
`timescale 1ns/1ns
`include "ibuf_defines.svh"

// random traffic through the instruction buffer, checked against per-slot queues
module tb_ibuf import ibuf_instr_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_CYCLES   = 6000;
    // stimulus length plus reset plus a generous margin
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_CYCLES + 200) * CLK_PERIOD;
    localparam int W            = `IBUF_ISSUE_WIDTH;

    logic     clk;
    logic     rst_n;
    logic     flush;
    logic     dec_valid;
    logic     dec_ready;
    uuid_t    dec_uuid;
    wid_t     dec_wid;
    tmask_t   dec_tmask;
    ex_type_e dec_ex_type;
    op_type_e dec_op_type;
    logic     dec_wb;
    word_t    dec_pc;
    word_t    dec_imm;
    reg_num_t dec_rd;
    reg_num_t dec_rs1;
    reg_num_t dec_rs2;
    logic     ibuf_valid   [W];
    logic     ibuf_ready   [W];
    logic     ibuf_pop     [W];
    uuid_t    ibuf_uuid    [W];
    wis_t     ibuf_wis     [W];
    tmask_t   ibuf_tmask   [W];
    ex_type_e ibuf_ex_type [W];
    op_type_e ibuf_op_type [W];
    logic     ibuf_wb      [W];
    word_t    ibuf_pc      [W];
    word_t    ibuf_imm     [W];
    reg_num_t ibuf_rd      [W];
    reg_num_t ibuf_rs1     [W];
    reg_num_t ibuf_rs2     [W];

    integer   seed;
    uuid_t    next_uuid;

    `include "ibuf_model.svh"

    ibuf_top u_dut (
        .clk, .rst_n, .flush, .dec_valid, .dec_ready, .dec_uuid, .dec_wid, .dec_tmask,
        .dec_ex_type, .dec_op_type, .dec_wb, .dec_pc, .dec_imm, .dec_rd, .dec_rs1,
        .dec_rs2, .ibuf_valid, .ibuf_ready, .ibuf_pop, .ibuf_uuid, .ibuf_wis, .ibuf_tmask,
        .ibuf_ex_type, .ibuf_op_type, .ibuf_wb, .ibuf_pc, .ibuf_imm, .ibuf_rd, .ibuf_rs1,
        .ibuf_rs2
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // compare every slot output and the decoder ready with the model, between edges
    task automatic check_outputs();
        exp_instr_t head;
        logic       has_head;
        for (int s = 0; s < W; s++) begin
            has_head = (exp_q[s].size() != 0);
            check_value($sformatf("ibuf_valid[%0d]", s), 64'(ibuf_valid[s]), 64'(has_head));
            check_value($sformatf("ibuf_pop[%0d]", s), 64'(ibuf_pop[s]),
                        64'(has_head && ibuf_ready[s]));
            if (has_head) begin
                head = exp_q[s][0];
                check_value($sformatf("ibuf_uuid[%0d]", s), 64'(ibuf_uuid[s]), 64'(head.uuid));
                check_value($sformatf("ibuf_wis[%0d]", s), 64'(ibuf_wis[s]), 64'(head.wis));
                check_value($sformatf("ibuf_tmask[%0d]", s), 64'(ibuf_tmask[s]),
                            64'(head.tmask));
                check_value($sformatf("ibuf_ex_type[%0d]", s), 64'(ibuf_ex_type[s]),
                            64'(head.ex_type));
                check_value($sformatf("ibuf_op_type[%0d]", s), 64'(ibuf_op_type[s]),
                            64'(head.op_type));
                check_value($sformatf("ibuf_wb[%0d]", s), 64'(ibuf_wb[s]), 64'(head.wb));
                check_value($sformatf("ibuf_pc[%0d]", s), 64'(ibuf_pc[s]), 64'(head.pc));
                check_value($sformatf("ibuf_imm[%0d]", s), 64'(ibuf_imm[s]), 64'(head.imm));
                check_value($sformatf("ibuf_rd[%0d]", s), 64'(ibuf_rd[s]), 64'(head.rd));
                check_value($sformatf("ibuf_rs1[%0d]", s), 64'(ibuf_rs1[s]), 64'(head.rs1));
                check_value($sformatf("ibuf_rs2[%0d]", s), 64'(ibuf_rs2[s]), 64'(head.rs2));
            end
        end
        check_value("dec_ready", 64'(dec_ready), 64'(exp_dec_ready(dec_wid)));
    endtask

    // present a fresh random instruction on the decoder port
    task automatic present_instr();
        int r;
        r = $random(seed);
        dec_uuid    <= next_uuid;
        next_uuid   <= next_uuid + 1'b1;
        dec_wid     <= wid_t'($unsigned(r) % `IBUF_NUM_WARPS);
        dec_tmask   <= tmask_t'(r[7:4]);
        dec_ex_type <= ex_type_e'(r[9:8]);
        dec_op_type <= op_type_e'({1'b0, r[12:10]});
        dec_wb      <= r[13];
        dec_rd      <= reg_num_t'(r[18:14]);
        dec_rs1     <= reg_num_t'(r[23:19]);
        dec_rs2     <= reg_num_t'(r[28:24]);
        dec_pc      <= word_t'($random(seed));
        dec_imm     <= word_t'($random(seed));
    endtask

    // new random inputs right after a rising edge, valid and fields hold until transfer
    task automatic drive_inputs(input int cyc, input logic xfer_s);
        int   r;
        logic stall_phase;
        // every third block of cycles issue mostly stalls so the queues fill up
        stall_phase = ((cyc / 200) % 3) == 1;
        r = $random(seed);
        flush <= ($unsigned(r) % 60) == 0;
        for (int s = 0; s < W; s++) begin
            r = $random(seed);
            ibuf_ready[s] <= stall_phase ? (r[2:0] == 3'd0) : (r[1:0] != 2'd0);
        end
        if (!dec_valid || xfer_s) begin
            r = $random(seed);
            if (r[1:0] != 2'd0) begin
                present_instr();
                dec_valid <= 1'b1;
            end else begin
                dec_valid <= 1'b0;
            end
        end
    endtask

    initial begin
        logic                flush_s;
        logic                xfer_s;
        int                  slot_s;
        exp_instr_t          instr_s;
        logic [W-1:0]        pop_s;
        seed      = 32'h8ba344ba;
        next_uuid = '0;
        rst_n     = 1'b0;
        flush     = 1'b0;
        dec_valid = 1'b0;
        dec_uuid  = '0;
        dec_wid   = '0;
        dec_tmask = '0;
        dec_ex_type = EX_ALU;
        dec_op_type = OP_ADD;
        dec_wb    = 1'b0;
        dec_pc    = '0;
        dec_imm   = '0;
        dec_rd    = '0;
        dec_rs1   = '0;
        dec_rs2   = '0;
        for (int s = 0; s < W; s++) begin
            ibuf_ready[s] = 1'b0;
            exp_occ[s]    = 0;
        end
        drain_left   = 0;
        pops_seen    = 0;
        dropped_seen = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(negedge clk);
            if (cyc == 0) begin
                // right after reset nothing is queued and the decoder may send
                for (int s = 0; s < W; s++) begin
                    check_value($sformatf("ibuf_valid[%0d]", s), 64'(ibuf_valid[s]), 64'(0));
                end
                check_value("dec_ready", 64'(dec_ready), 64'(1));
            end
            check_outputs();
            // capture what the coming edge will act on
            flush_s         = flush;
            xfer_s          = dec_valid && dec_ready;
            slot_s          = int'(dec_wid) % W;
            instr_s.uuid    = dec_uuid;
            instr_s.wis     = `IBUF_WIS_W'(int'(dec_wid) / W);
            instr_s.tmask   = dec_tmask;
            instr_s.ex_type = dec_ex_type;
            instr_s.op_type = dec_op_type;
            instr_s.wb      = dec_wb;
            instr_s.pc      = dec_pc;
            instr_s.imm     = dec_imm;
            instr_s.rd      = dec_rd;
            instr_s.rs1     = dec_rs1;
            instr_s.rs2     = dec_rs2;
            for (int s = 0; s < W; s++) begin
                pop_s[s] = (exp_q[s].size() != 0) && ibuf_ready[s];
            end
            @(posedge clk);
            model_clock(flush_s, xfer_s, slot_s, instr_s, pop_s);
            drive_inputs(cyc, xfer_s);
        end
        $display("ran %0d cycles, %0d entries issued, %0d wrong-path instructions dropped",
                 NUM_CYCLES, pops_seen, dropped_seen);
        $display("Simulation finished: PASS");
        $finish;
    end

    // ends a run that never reaches the end of its stimulus
    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns before all stimulus cycles ran",
                 WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog timeout");
    end

endmodule

// File: compile.f
+incdir+design
+incdir+sim
design/ibuf_instr_pkg.sv
design/ibuf_ctrl_pkg.sv
design/ibuf_slot_router.sv
design/ibuf_fifo.sv
design/ibuf_flush_fsm.sv
design/ibuf_window_timer.sv
design/ibuf_top.sv
sim/tb_ibuf.sv

// File: run_sim.sh
#!/bin/sh
# builds the instruction buffer testbench with Verilator and runs it
# the exit status of this script is the exit status of the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f compile.f \
    --top-module tb_ibuf \
    -Mdir obj_dir \
    && ./obj_dir/Vtb_ibuf \
    || { echo "ibuf simulation did not complete cleanly"; exit 1; }
